/* logic/data_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module data_mem_top
    import mem_access_pkg::*;
    import mem_map_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [`XLEN-1:0]   mem_raddr,
    input  wire logic [`XLEN-1:0]   mem_waddr,
    input  wire logic [`XLEN-1:0]   mem_wdata,
    input  wire logic               mem_ren,
    input  wire logic               mem_wen,
    input  wire access_width_t      mem_width,
    input  wire logic               load_unsigned,
    output logic [`XLEN-1:0]        mem_rdata,
    output logic                    rfault,
    output logic                    wfault,
    output fault_cause_t            fault_cause
);

    // read side decode
    mem_region_t                rd_region;
    logic [`RAM_ROW_BITS-1:0]   rd_row;
    logic [2:0]                 rd_offset;
    logic                       rd_misaligned;

    // write side decode
    mem_region_t                wr_region;
    logic [`RAM_ROW_BITS-1:0]   wr_row;
    logic [2:0]                 wr_offset;
    logic                       wr_misaligned;

    byte_en_t                   wr_byte_en;
    logic [63:0]                wr_row_data;
    logic [63:0]                ram_rdata;

    logic                       ram_ren;
    logic                       ram_wen;
    logic                       rd_fault;
    logic                       wr_fault;
    fault_cause_t               rd_cause;
    fault_cause_t               wr_cause;

    mem_region_decode read_decode (
        .addr       (mem_raddr),
        .width      (mem_width),
        .region     (rd_region),
        .row        (rd_row),
        .offset     (rd_offset),
        .misaligned (rd_misaligned)
    );

    mem_region_decode write_decode (
        .addr       (mem_waddr),
        .width      (mem_width),
        .region     (wr_region),
        .row        (wr_row),
        .offset     (wr_offset),
        .misaligned (wr_misaligned)
    );

    store_lane_align store_align (
        .width      (mem_width),
        .offset     (wr_offset),
        .wdata      (mem_wdata),
        .byte_en    (wr_byte_en),
        .row_data   (wr_row_data)
    );

    // only accesses that are in the window and aligned reach the RAM
    assign ram_ren = mem_ren & (rd_region == region_ram) & ~rd_misaligned;
    assign ram_wen = mem_wen & (wr_region == region_ram) & ~wr_misaligned;

    assign rd_fault = mem_ren & ~ram_ren;
    assign wr_fault = mem_wen & ~ram_wen;

    // alignment wins over range
    assign rd_cause = rd_misaligned ? cause_align : cause_range;
    assign wr_cause = wr_misaligned ? cause_align : cause_range;

    data_ram ram (
        .clk        (clk),
        .wen        (ram_wen),
        .wrow       (wr_row),
        .byte_en    (wr_byte_en),
        .wdata      (wr_row_data),
        .ren        (ram_ren),
        .rrow       (rd_row),
        .rdata      (ram_rdata)
    );

    // faulted reads never update the load path, so mem_rdata holds
    load_extract load_unit (
        .clk            (clk),
        .rst            (rst),
        .ren            (ram_ren),
        .width          (mem_width),
        .unsigned_load  (load_unsigned),
        .offset         (rd_offset),
        .row            (ram_rdata),
        .rdata          (mem_rdata)
    );

    // one-cycle fault pulses, read cause first when both fault
    always_ff @(posedge clk) begin
        if (rst) begin
            rfault      <= 1'b0;
            wfault      <= 1'b0;
            fault_cause <= cause_none;
        end else begin
            rfault <= rd_fault;
            wfault <= wr_fault;
            if (rd_fault) begin
                fault_cause <= rd_cause;
            end else if (wr_fault) begin
                fault_cause <= wr_cause;
            end else begin
                fault_cause <= cause_none;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module data_ram
    import mem_access_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       wen,
    input  wire logic [`RAM_ROW_BITS-1:0]   wrow,
    input  wire byte_en_t                   byte_en,
    input  wire logic [63:0]                wdata,
    input  wire logic                       ren,
    input  wire logic [`RAM_ROW_BITS-1:0]   rrow,
    output logic [63:0]                     rdata
);

    localparam int row_count = 2 ** `RAM_ROW_BITS;

    // row storage, contents undefined until written
    logic [63:0] mem [row_count];

    // byte-enabled write
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int lane = 0; lane < 8; lane++) begin
                if (byte_en[lane]) begin
                    mem[wrow][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    // registered read
    // a write to the same row in this cycle is not seen yet
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[rrow];
        end
    end

endmodule

`default_nettype wire

/* logic/load_extract.sv */
`timescale 1ns/1ps
`default_nettype none

module load_extract
    import mem_access_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            ren,
    input  wire access_width_t   width,
    input  wire logic            unsigned_load,
    input  wire logic [2:0]      offset,
    input  wire logic [63:0]     row,
    output logic [63:0]          rdata
);

    // selectors captured with the read, used when the row arrives
    access_width_t width_q;
    logic          unsigned_q;
    logic [2:0]    offset_q;
    // a read was issued last cycle, so row is fresh
    logic          ren_q;

    ram_row_u      row_v;
    logic [63:0]   extracted;
    // last load result, held between reads
    logic [63:0]   result_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            width_q    <= width_dword;
            unsigned_q <= 1'b0;
            offset_q   <= 3'd0;
            ren_q      <= 1'b0;
        end else begin
            ren_q <= ren;
            if (ren) begin
                width_q    <= width;
                unsigned_q <= unsigned_load;
                offset_q   <= offset;
            end
        end
    end

    assign row_v = row;

    // pick the lanes, then zero or sign extend
    always_comb begin
        case (width_q)
            width_byte: begin
                extracted = {{56{~unsigned_q & row_v.bytes[offset_q][7]}},
                             row_v.bytes[offset_q]};
            end
            width_half: begin
                extracted = {{48{~unsigned_q & row_v.halves[offset_q[2:1]][15]}},
                             row_v.halves[offset_q[2:1]]};
            end
            width_word: begin
                extracted = {{32{~unsigned_q & row_v.words[offset_q[2]][31]}},
                             row_v.words[offset_q[2]]};
            end
            default: begin
                extracted = row_v;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (ren_q) begin
            result_q <= extracted;
        end
    end

    // new value in the cycle after the read, otherwise the held one
    assign rdata = ren_q ? extracted : result_q;

endmodule

`default_nettype wire

/* logic/mem_access_pkg.sv */
`default_nettype none

package mem_access_pkg;

    // access size shared by loads and stores
    typedef enum logic [1:0] {
        width_byte  = 2'd0,
        width_half  = 2'd1,
        width_word  = 2'd2,
        width_dword = 2'd3
    } access_width_t;

    // one enable bit per byte lane of a row
    typedef logic [7:0] byte_en_t;

    // one 64-bit row seen as bytes, halves or words
    // lane 0 is the lowest addressed byte
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
    } ram_row_u;

endpackage

`default_nettype wire

/* logic/mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data path width of one RAM row
`define XLEN 64

// byte address where the RAM window starts
// must stay 8-byte aligned so the low address bits are the lane offset
`define RAM_BASE 64'h0000_0000_8000_0000

// row index bits for 2**6 rows of 8 bytes by default
// window size in bytes is 8 << RAM_ROW_BITS
`define RAM_ROW_BITS 6

`endif

/* logic/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    // where an address lands
    typedef enum logic {
        region_ram  = 1'b0,
        region_none = 1'b1
    } mem_region_t;

    // reason for a rejected access
    // align is checked ahead of range
    typedef enum logic [1:0] {
        cause_none  = 2'd0,
        cause_range = 2'd1,
        cause_align = 2'd2
    } fault_cause_t;

endpackage

`default_nettype wire

/* logic/mem_region_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_region_decode
    import mem_access_pkg::*;
    import mem_map_pkg::*;
(
    input  wire logic [`XLEN-1:0]         addr,
    input  wire access_width_t            width,
    output mem_region_t                   region,
    output logic [`RAM_ROW_BITS-1:0]      row,
    output logic [2:0]                    offset,
    output logic                          misaligned
);

    // window size in bytes, 8 bytes per row
    localparam logic [`XLEN-1:0] window_bytes =
        {{(`XLEN-1){1'b0}}, 1'b1} << (`RAM_ROW_BITS + 3);

    // byte address relative to the window base
    logic [`XLEN-1:0] rel_addr;

    assign rel_addr = addr - `RAM_BASE;

    // below the base wraps to a huge value, so one compare covers both sides
    assign region = (rel_addr < window_bytes) ? region_ram : region_none;

    // row index above the lane bits
    assign row = rel_addr[`RAM_ROW_BITS+2:3];

    // lane within the row
    // base is row aligned, so these match addr[2:0]
    assign offset = rel_addr[2:0];

    // offset must be a multiple of the access size
    always_comb begin
        case (width)
            width_byte:  misaligned = 1'b0;
            width_half:  misaligned = offset[0];
            width_word:  misaligned = |offset[1:0];
            width_dword: misaligned = |offset;
            default:     misaligned = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* logic/store_lane_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_lane_align
    import mem_access_pkg::*;
(
    input  wire access_width_t   width,
    input  wire logic [2:0]      offset,
    input  wire logic [63:0]     wdata,
    output byte_en_t             byte_en,
    output logic [63:0]          row_data
);

    // contiguous mask anchored at lane 0
    byte_en_t base_mask;

    always_comb begin
        case (width)
            width_byte:  base_mask = 8'h01;
            width_half:  base_mask = 8'h03;
            width_word:  base_mask = 8'h0f;
            default:     base_mask = 8'hff;
        endcase
    end

    // move the mask up to the addressed lanes
    // misaligned shifts lose bits, but those writes are blocked upstream
    assign byte_en = base_mask << offset;

    // repeat the low bytes of wdata across the row
    // any aligned offset then finds its data already in place
    always_comb begin
        case (width)
            width_byte:  row_data = {8{wdata[7:0]}};
            width_half:  row_data = {4{wdata[15:0]}};
            width_word:  row_data = {2{wdata[31:0]}};
            default:     row_data = wdata;
        endcase
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module data_mem_tb -o data_mem_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/data_mem_sim)
echo "$out"
echo "$out" | grep -q "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/data_mem_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module data_mem_assert
    import mem_access_pkg::*;
    import mem_map_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               mem_wen,
    input  wire logic [`XLEN-1:0]   mem_waddr,
    input  wire access_width_t      mem_width,
    input  wire logic               ram_wen,
    input  wire logic               rfault,
    input  wire logic               wfault,
    input  wire fault_cause_t       fault_cause
);

    // write address relative to the window base
    logic [`XLEN-1:0] rel_addr;
    // low address bits that must be zero for this width
    logic [2:0]       lane_mask;
    logic             write_bad;

    assign rel_addr = mem_waddr - `RAM_BASE;

    always_comb begin
        case (mem_width)
            width_byte:  lane_mask = 3'd0;
            width_half:  lane_mask = 3'd1;
            width_word:  lane_mask = 3'd3;
            default:     lane_mask = 3'd7;
        endcase
    end

    // outside the window or off its natural boundary
    assign write_bad = (rel_addr >= (64'd8 << `RAM_ROW_BITS)) ||
                       ((mem_waddr[2:0] & lane_mask) != 3'd0);

    // strobes come out of reset low
    assert property (@(posedge clk) $fell(rst) |-> !rfault && !wfault)
        else $error("fault strobe high in the cycle after reset");

    // rejected store leaves the RAM write port idle
    assert property (@(posedge clk) disable iff (rst) mem_wen && write_bad |-> !ram_wen)
        else $error("faulting write enabled the RAM");

    // read fault always names a cause
    assert property (@(posedge clk) disable iff (rst) rfault |-> fault_cause != cause_none)
        else $error("read fault without a cause");

endmodule

bind data_mem_top data_mem_assert checker_inst (
    .clk            (clk),
    .rst            (rst),
    .mem_wen        (mem_wen),
    .mem_waddr      (mem_waddr),
    .mem_width      (mem_width),
    .ram_wen        (ram_wen),
    .rfault         (rfault),
    .wfault         (wfault),
    .fault_cause    (fault_cause)
);

`default_nettype wire

/* testbench/data_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module data_mem_tb
    import mem_access_pkg::*;
    import mem_map_pkg::*;
();

    localparam int window_bytes = 8 << `RAM_ROW_BITS;
    localparam int row_count = 1 << `RAM_ROW_BITS;

    logic            clk;
    logic            rst;
    logic [63:0]     mem_raddr;
    logic [63:0]     mem_waddr;
    logic [63:0]     mem_wdata;
    logic            mem_ren;
    logic            mem_wen;
    access_width_t   mem_width;
    logic            load_unsigned;
    logic [63:0]     mem_rdata;
    logic            rfault;
    logic            wfault;
    fault_cause_t    fault_cause;

    // byte-level model of the window
    logic [7:0]      model_mem [window_bytes];
    // load results due in the next cycle
    logic [63:0]     rdata_q [$];
    logic [63:0]     last_rdata;
    logic            exp_rfault;
    logic            exp_wfault;
    logic [1:0]      exp_cause;
    logic [31:0]     lfsr_state;
    int              errors;
    int              checks;
    logic            stim_done;

    data_mem_top dut (
        .clk            (clk),
        .rst            (rst),
        .mem_raddr      (mem_raddr),
        .mem_waddr      (mem_waddr),
        .mem_wdata      (mem_wdata),
        .mem_ren        (mem_ren),
        .mem_wen        (mem_wen),
        .mem_width      (mem_width),
        .load_unsigned  (load_unsigned),
        .mem_rdata      (mem_rdata),
        .rfault         (rfault),
        .wfault         (wfault),
        .fault_cause    (fault_cause)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // inputs idle, reset held for 5 cycles, released on a falling edge
    initial begin
        rst = 1'b1;
        mem_raddr = '0;
        mem_waddr = '0;
        mem_wdata = '0;
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        mem_width = width_dword;
        load_unsigned = 1'b0;
        last_rdata = '0;
        exp_rfault = 1'b0;
        exp_wfault = 1'b0;
        exp_cause = cause_none;
        lfsr_state = 32'd89;
        errors = 0;
        checks = 0;
        stim_done = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] take_bits(input int nbits);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
            value = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // random window address aligned to size
    function automatic logic [63:0] window_addr(input int size);
        logic [63:0] rel;
        rel = take_bits(`RAM_ROW_BITS + 3) & ~64'(size - 1);
        return `RAM_BASE + rel;
    endfunction

    // model bytes at rel, then zero or sign extension
    function automatic logic [63:0] model_load(input int rel, input int size, input logic uns);
        logic [63:0] value;
        logic        sign;
        value = '0;
        for (int i = 0; i < size; i++) begin
            value[i*8 +: 8] = model_mem[rel + i];
        end
        sign = value[size*8 - 1] & ~uns;
        for (int i = size * 8; i < 64; i++) begin
            value[i] = sign;
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
        end
    endtask

    // check the previous request's results, then drive the next request
    task automatic issue(input logic ren, input logic [63:0] raddr, input logic wen,
                         input logic [63:0] waddr, input logic [63:0] wdata,
                         input logic [1:0] width, input logic uns);
        logic [63:0] rrel;
        logic [63:0] wrel;
        int          size;
        logic        rmis;
        logic        wmis;
        logic        rbad;
        logic        wbad;
        @(negedge clk);
        check_value("rfault", 64'(rfault), 64'(exp_rfault));
        check_value("wfault", 64'(wfault), 64'(exp_wfault));
        check_value("fault_cause", 64'(fault_cause), 64'(exp_cause));
        if (rdata_q.size() > 0) begin
            last_rdata = rdata_q.pop_front();
        end
        check_value("mem_rdata", mem_rdata, last_rdata);
        size = 1 << width;
        rrel = raddr - `RAM_BASE;
        wrel = waddr - `RAM_BASE;
        rmis = (raddr[2:0] & 3'(size - 1)) != 3'd0;
        wmis = (waddr[2:0] & 3'(size - 1)) != 3'd0;
        rbad = rmis | (rrel >= 64'(window_bytes));
        wbad = wmis | (wrel >= 64'(window_bytes));
        exp_rfault = ren & rbad;
        exp_wfault = wen & wbad;
        // read cause first, align over range
        if (exp_rfault) begin
            exp_cause = rmis ? cause_align : cause_range;
        end else if (exp_wfault) begin
            exp_cause = wmis ? cause_align : cause_range;
        end else begin
            exp_cause = cause_none;
        end
        // read sees the model before this cycle's store
        if (ren && !rbad) begin
            rdata_q.push_back(model_load(int'(rrel), size, uns));
        end
        if (wen && !wbad) begin
            for (int i = 0; i < size; i++) begin
                model_mem[int'(wrel) + i] = wdata[i*8 +: 8];
            end
        end
        mem_ren = ren;
        mem_raddr = raddr;
        mem_wen = wen;
        mem_waddr = waddr;
        mem_wdata = wdata;
        mem_width = access_width_t'(width);
        load_unsigned = uns;
    endtask

    initial begin : stimulus
        int          waited;
        logic [63:0] addr;
        logic [1:0]  width;
        waited = 0;
        @(posedge clk);
        while (rst && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rst) begin
            errors++;
            $display("reset was still high after %0d cycles", waited);
        end else begin
            // fill every row, read each back one cycle later
            for (int r = 0; r < row_count; r++) begin
                addr = `RAM_BASE + 64'(r * 8);
                issue(1'b0, '0, 1'b1, addr, take_bits(64), 2'd3, 1'b0);
                issue(1'b1, addr, 1'b0, '0, '0, 2'd3, 1'b0);
            end
            // mixed aligned traffic
            repeat (300) begin
                width = 2'(take_bits(2));
                issue(1'(take_bits(1)), window_addr(1 << width), 1'(take_bits(1)),
                      window_addr(1 << width), take_bits(64), width, 1'(take_bits(1)));
            end
            // read and write on one address in the same cycle
            repeat (20) begin
                width = 2'(take_bits(2));
                addr = window_addr(1 << width);
                issue(1'b1, addr, 1'b1, addr, take_bits(64), width, 1'(take_bits(1)));
            end
            // odd addresses, then a readback of the row
            repeat (20) begin
                width = 2'(take_bits(2));
                if (width == 2'd0) begin
                    width = 2'd2;
                end
                addr = window_addr(8) | 64'd1;
                issue(1'b1, addr, 1'b0, '0, '0, width, 1'b0);
                issue(1'b0, '0, 1'b1, addr, take_bits(64), width, 1'b0);
                issue(1'b1, addr & ~64'd7, 1'b0, '0, '0, 2'd3, 1'b0);
            end
            // above and below the window
            repeat (20) begin
                addr = `RAM_BASE - 64'd8 - (take_bits(16) << 3);
                issue(1'b0, '0, 1'b1, addr, take_bits(64), 2'd3, 1'b0);
                addr = `RAM_BASE + 64'(window_bytes) + (take_bits(16) << 3);
                issue(1'b1, addr, 1'b1, addr, take_bits(64), 2'd3, 1'b0);
                issue(1'b1, window_addr(8), 1'b0, '0, '0, 2'd3, 1'b0);
            end
            // idle cycle picks up the last results
            issue(1'b0, '0, 1'b0, '0, '0, 2'd3, 1'b0);
        end
        stim_done = 1'b1;
    end

    initial begin : finish_run
        int waited;
        waited = 0;
        @(posedge clk);
        while (!stim_done && waited < 5000) begin
            @(posedge clk);
            waited++;
        end
        if (!stim_done) begin
            errors++;
            $display("stimulus did not finish within %0d cycles", waited);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/mem_access_pkg.sv
logic/mem_map_pkg.sv
logic/mem_region_decode.sv
logic/store_lane_align.sv
logic/data_ram.sv
logic/load_extract.sv
logic/data_mem_top.sv
testbench/data_mem_assert.sv
testbench/data_mem_tb.sv
